/* include/div_consts.svh */
////////////////////
// divide unit constants
// word width, step counter width and fixed request-to-result latency
////////////////////
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand and quotient width in bits
`define DIV_BW 32

// step counter width, wide enough to hold a count of DIV_BW
`define DIV_LGBW 6

// edges from the edge that accepts i_wr until o_valid is sampled high
// one edge for operand prep, DIV_BW steps in the core, one edge for the result
`define DIV_LATENCY (`DIV_BW + 2)

`endif

/* source/div_pkg.sv */
////////////////////
// divide unit package
// shared word, flag, opcode and sequencer state types
////////////////////
`default_nettype none

`include "div_consts.svh"

package div_pkg;

	// one operand, magnitude or quotient word
	typedef logic [`DIV_BW-1:0] div_word_t;

	// condition flags in the CPU's v/n/c/z order, msb first
	// v and c never set for a divide
	typedef struct packed {
		logic v;
		logic n;
		logic c;
		logic z;
	} div_flags_t;

	// request opcode
	typedef enum logic {
		DIV_OP_UNSIGNED = 1'b0,
		DIV_OP_SIGNED   = 1'b1
	} div_op_e;

	// core sequencer
	// IDLE waits for a start, RUN does the shift-subtract steps,
	// DONE presents the raw quotient for a single cycle
	typedef enum logic [1:0] {
		DIV_ST_IDLE = 2'd0,
		DIV_ST_RUN  = 2'd1,
		DIV_ST_DONE = 2'd2
	} div_state_e;

endpackage

`default_nettype wire

/* source/div_operand_prep.sv */
////////////////////
// divide operand preparation
// registers a request, turns signed operands into magnitudes,
// works out the result sign and spots a zero divisor
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "div_consts.svh"

module div_operand_prep
	import div_pkg::*;
(
	input  wire            i_clk,
	input  wire            i_reset,
	input  wire            i_wr,
	input  wire            i_busy,
	input  wire div_op_e   i_op,
	input  wire div_word_t i_numerator,
	input  wire div_word_t i_denominator,
	output logic           o_start,
	output div_word_t      o_num_mag,
	output div_word_t      o_den_mag,
	output logic           o_negate,
	output logic           o_div_zero
);

	logic s_accept;
	logic s_num_neg;
	logic s_den_neg;

	// a request only counts when the core is free
	assign s_accept = i_wr && !i_busy;

	// sign bits matter only for a signed divide
	assign s_num_neg = (i_op == DIV_OP_SIGNED) && i_numerator[`DIV_BW-1];
	assign s_den_neg = (i_op == DIV_OP_SIGNED) && i_denominator[`DIV_BW-1];

	////////////////////
	// start pulse
	////////////////////

	// one cycle after the accepting edge the core gets its start
	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_start <= 1'b0;
		else
			o_start <= s_accept;
	end

	////////////////////
	// operand registers
	////////////////////

	// the most negative value maps onto itself here, which is
	// still the right unsigned magnitude
	// sign and zero divisor stay put until the next request so the
	// result stage can pick them up at the end
	always_ff @(posedge i_clk) begin
		if (s_accept) begin
			o_num_mag  <= s_num_neg ? (~i_numerator + 1'b1) : i_numerator;
			o_den_mag  <= s_den_neg ? (~i_denominator + 1'b1) : i_denominator;
			o_negate   <= s_num_neg ^ s_den_neg;
			o_div_zero <= (i_denominator == '0);
		end
	end

	// the CPU must hold off while a divide is in flight
	a_no_wr_while_busy: assert property (
		@(posedge i_clk) disable iff (i_reset)
		i_wr |-> !i_busy
	);

endmodule

`default_nettype wire

/* source/div_core.sv */
////////////////////
// divide core
// restoring shift-subtract over DIV_BW steps on unsigned magnitudes,
// owns the busy indication for the whole unit
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "div_consts.svh"

module div_core
	import div_pkg::*;
(
	input  wire            i_clk,
	input  wire            i_reset,
	input  wire            i_start,
	input  wire div_word_t i_num_mag,
	input  wire div_word_t i_den_mag,
	output logic           o_busy,
	output logic           o_done,
	output div_word_t      o_quotient
);

	// count value at which the last step is taken
	localparam logic [`DIV_LGBW-1:0] LAST_STEP = `DIV_LGBW'(`DIV_BW - 1);

	div_state_e r_state;
	logic [`DIV_LGBW-1:0] r_count;

	// partial remainder, divisor copy and the combined numerator and
	// quotient register
	// numerator bits leave at the top while quotient bits enter at the bottom
	div_word_t r_rem;
	div_word_t r_den;
	div_word_t r_quo;

	div_word_t s_rem_src;
	div_word_t s_quo_src;
	div_word_t s_den_src;
	logic [`DIV_BW:0] s_trial;
	logic [`DIV_BW:0] s_diff;
	logic s_fits;
	logic s_step;

	////////////////////
	// one divide step
	////////////////////

	// the first step runs on the edge that sees start, straight from
	// the prep outputs, so no separate load cycle is spent
	assign s_rem_src = i_start ? '0 : r_rem;
	assign s_quo_src = i_start ? i_num_mag : r_quo;
	assign s_den_src = i_start ? i_den_mag : r_den;

	// bring down the next numerator bit and try the subtraction
	assign s_trial = {s_rem_src, s_quo_src[`DIV_BW-1]};
	assign s_diff  = s_trial - {1'b0, s_den_src};

	// no borrow means the divisor fits
	// a zero divisor always fits, giving an all-ones quotient
	assign s_fits = !s_diff[`DIV_BW];

	assign s_step = i_start || (r_state == DIV_ST_RUN);

	always_ff @(posedge i_clk) begin
		if (s_step) begin
			r_rem <= s_fits ? s_diff[`DIV_BW-1:0] : s_trial[`DIV_BW-1:0];
			r_quo <= {s_quo_src[`DIV_BW-2:0], s_fits};
		end
		if (i_start)
			r_den <= i_den_mag;
	end

	////////////////////
	// sequencer
	////////////////////

	// start takes step one and leaves a count of one behind
	// RUN then takes the remaining steps and hands over to DONE
	// after step DIV_BW
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_state <= DIV_ST_IDLE;
			r_count <= '0;
		end else begin
			case (r_state)
				DIV_ST_IDLE: begin
					if (i_start) begin
						r_state <= DIV_ST_RUN;
						r_count <= `DIV_LGBW'(1);
					end
				end
				DIV_ST_RUN: begin
					r_count <= r_count + 1'b1;
					if (r_count == LAST_STEP)
						r_state <= DIV_ST_DONE;
				end
				DIV_ST_DONE: r_state <= DIV_ST_IDLE;
				default:     r_state <= DIV_ST_IDLE;
			endcase
		end
	end

	// busy rises with start so the CPU sees it right after the request,
	// and it drops on the same edge that registers the result
	assign o_busy     = i_start || (r_state != DIV_ST_IDLE);
	assign o_done     = (r_state == DIV_ST_DONE);
	assign o_quotient = r_quo;

	// a start is followed by exactly DIV_BW steps and then a single done cycle
	a_done_pulse: assert property (
		@(posedge i_clk) disable iff (i_reset)
		i_start |-> ##(`DIV_BW) o_done ##1 !o_done
	);

	// prep only starts a divide when the core has gone idle
	a_start_idle: assert property (
		@(posedge i_clk) disable iff (i_reset)
		i_start |-> (r_state == DIV_ST_IDLE)
	);

endmodule

`default_nettype wire

/* source/div_result.sv */
////////////////////
// divide result stage
// applies the sign, handles a zero divisor and registers the result
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "div_consts.svh"

module div_result
	import div_pkg::*;
(
	input  wire            i_clk,
	input  wire            i_reset,
	input  wire            i_done,
	input  wire div_word_t i_quotient,
	input  wire            i_negate,
	input  wire            i_div_zero,
	output logic           o_valid,
	output div_word_t      o_quotient,
	output logic           o_err,
	output div_flags_t     o_flags
);

	div_word_t  s_signed_q;
	div_word_t  s_final_q;
	div_flags_t s_flags;

	// two's complement negate when the operand signs differed
	// the most negative over minus one wraps back onto itself
	assign s_signed_q = i_negate ? (~i_quotient + 1'b1) : i_quotient;

	// the raw core output is meaningless for a zero divisor
	assign s_final_q = i_div_zero ? '0 : s_signed_q;

	// overflow and carry never apply to a divide
	assign s_flags.v = 1'b0;
	assign s_flags.n = !i_div_zero && s_final_q[`DIV_BW-1];
	assign s_flags.c = 1'b0;
	assign s_flags.z = !i_div_zero && (s_final_q == '0);

	////////////////////
	// output registers
	////////////////////

	// valid, error and flags all drop back outside the valid cycle
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			o_err   <= 1'b0;
			o_flags <= '0;
		end else begin
			o_valid <= i_done;
			o_err   <= i_done && i_div_zero;
			o_flags <= i_done ? s_flags : '0;
		end
	end

	// quotient only loads with a finished divide and holds otherwise
	always_ff @(posedge i_clk) begin
		if (i_done)
			o_quotient <= s_final_q;
	end

	// a result and its error bit last for one cycle only
	a_valid_pulse: assert property (
		@(posedge i_clk) disable iff (i_reset)
		o_valid |=> (!o_valid && !o_err)
	);

endmodule

`default_nettype wire

/* source/div_unit.sv */
////////////////////
// integer divide unit
// operand prep, shift-subtract core and result stage, one divide in flight
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "div_consts.svh"

module div_unit
	import div_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_reset,
	input  wire             i_wr,
	input  wire div_op_e    i_op,
	input  wire div_word_t  i_numerator,
	input  wire div_word_t  i_denominator,
	output logic            o_busy,
	output logic            o_valid,
	output logic            o_err,
	output div_word_t       o_quotient,
	output div_flags_t      o_flags
);

	// prep to core
	logic      prep_start;
	div_word_t prep_num_mag;
	div_word_t prep_den_mag;

	// prep to result, stable for the life of the divide
	logic      prep_negate;
	logic      prep_div_zero;

	// core to result
	logic      core_done;
	div_word_t core_quotient;

	////////////////////
	// stages
	////////////////////

	// busy from the core also gates new requests in prep
	div_operand_prep u_prep (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_wr          (i_wr),
		.i_busy        (o_busy),
		.i_op          (i_op),
		.i_numerator   (i_numerator),
		.i_denominator (i_denominator),
		.o_start       (prep_start),
		.o_num_mag     (prep_num_mag),
		.o_den_mag     (prep_den_mag),
		.o_negate      (prep_negate),
		.o_div_zero    (prep_div_zero)
	);

	div_core u_core (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_start    (prep_start),
		.i_num_mag  (prep_num_mag),
		.i_den_mag  (prep_den_mag),
		.o_busy     (o_busy),
		.o_done     (core_done),
		.o_quotient (core_quotient)
	);

	div_result u_result (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_done     (core_done),
		.i_quotient (core_quotient),
		.i_negate   (prep_negate),
		.i_div_zero (prep_div_zero),
		.o_valid    (o_valid),
		.o_quotient (o_quotient),
		.o_err      (o_err),
		.o_flags    (o_flags)
	);

	// the CPU relies on busy and valid never overlapping
	a_busy_valid: assert property (
		@(posedge i_clk) disable iff (i_reset)
		!(o_busy && o_valid)
	);

	// an accepted request always comes back after the fixed latency
	a_latency: assert property (
		@(posedge i_clk) disable iff (i_reset)
		(i_wr && !o_busy) |-> ##(`DIV_LATENCY) o_valid
	);

endmodule

`default_nettype wire

/* dv/div_unit_tb.sv */
////////////////////
// divide unit testbench
// directed patterns from a file, then seeded random requests against a model
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "div_consts.svh"

module div_unit_tb
	import div_pkg::*;
();

	// one divide with its expected result
	typedef struct packed {
		div_op_e    op;
		div_word_t  num;
		div_word_t  den;
		div_word_t  quo;
		logic       err;
		div_flags_t flags;
	} request_t;

	logic       i_clk;
	logic       i_reset;
	logic       i_wr;
	div_op_e    i_op;
	div_word_t  i_numerator;
	div_word_t  i_denominator;
	logic       o_busy;
	logic       o_valid;
	logic       o_err;
	div_word_t  o_quotient;
	div_flags_t o_flags;

	request_t    patterns[$];
	logic [31:0] lcg_state = 32'd23938;
	int          req_index = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	int          quotient_errors = 0;
	int          errbit_errors = 0;
	int          flag_errors = 0;
	int          timing_errors = 0;
	int          file_errors = 0;

	div_unit u_dut (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_wr          (i_wr),
		.i_op          (i_op),
		.i_numerator   (i_numerator),
		.i_denominator (i_denominator),
		.o_busy        (o_busy),
		.o_valid       (o_valid),
		.o_err         (o_err),
		.o_quotient    (o_quotient),
		.o_flags       (o_flags)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	////////////////////
	// stimulus helpers
	////////////////////

	// the low LCG bits repeat quickly, so a word is built from two top halves
	function automatic div_word_t random_word();
		logic [31:0] hi;
		hi = lcg_state * 32'd1103515245 + 32'd12345;
		lcg_state = hi * 32'd1103515245 + 32'd12345;
		return {hi[31:16], lcg_state[31:16]};
	endfunction

	// expected result straight from the divide rules
	// 64-bit signed division rounds toward zero and truncation wraps min / -1
	function automatic request_t ref_divide(div_op_e op, div_word_t num, div_word_t den);
		request_t r;
		longint   sq;
		r.op  = op;
		r.num = num;
		r.den = den;
		r.quo = '0;
		r.err = (den == '0);
		r.flags = '0;
		if (den != '0) begin
			sq = longint'($signed(num)) / longint'($signed(den));
			r.quo = (op == DIV_OP_SIGNED) ? sq[`DIV_BW-1:0] : num / den;
			r.flags.n = r.quo[`DIV_BW-1];
			r.flags.z = (r.quo == '0);
		end
		return r;
	endfunction

	// lines starting with # hold column notes
	task automatic load_patterns();
		int          fd;
		string       line;
		logic [31:0] f_op, f_num, f_den, f_quo, f_err, f_flags;
		request_t    req;
		fd = $fopen("dv/div_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file dv/div_patterns.txt");
			file_errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				if ($sscanf(line, "%h %h %h %h %h %h",
						f_op, f_num, f_den, f_quo, f_err, f_flags) == 6) begin
					req.op    = div_op_e'(f_op[0]);
					req.num   = f_num;
					req.den   = f_den;
					req.quo   = f_quo;
					req.err   = f_err[0];
					req.flags = div_flags_t'(f_flags[3:0]);
					patterns.push_back(req);
				end else begin
					$display("pattern line could not be read: %s", line);
					file_errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	////////////////////
	// checks
	////////////////////

	task automatic check_quotient(div_word_t expected);
		if (o_quotient !== expected) begin
			$display("** Error at %0t: request %0d quotient expected %h, got %h",
				$time, req_index, expected, o_quotient);
			quotient_errors++;
		end
	endtask

	task automatic check_err(bit expected);
		if (o_err !== expected) begin
			$display("** Error at %0t: request %0d err expected %b, got %b",
				$time, req_index, expected, o_err);
			errbit_errors++;
		end
	endtask

	task automatic check_flags(div_flags_t expected);
		if (o_flags !== expected) begin
			$display("** Error at %0t: request %0d flags expected %b, got %b",
				$time, req_index, expected, o_flags);
			flag_errors++;
		end
	endtask

	// issue one request on a falling edge and follow the handshake to its
	// result, edges are counted from the rising edge that samples i_wr
	task automatic run_request(request_t req);
		int edges;
		if (o_busy !== 1'b0 || o_valid !== 1'b0) begin
			$display("unit was not idle before request %0d at %0t", req_index, $time);
			timing_errors++;
		end
		i_wr = 1'b1;
		i_op = req.op;
		i_numerator = req.num;
		i_denominator = req.den;
		@(posedge i_clk);
		@(negedge i_clk);
		i_wr = 1'b0;
		edges = 1;
		while (o_valid !== 1'b1) begin
			if (o_busy !== 1'b1) begin
				$display("o_busy was low while request %0d was in flight at %0t",
					req_index, $time);
				timing_errors++;
			end
			@(posedge i_clk);
			@(negedge i_clk);
			edges++;
		end
		if (edges != `DIV_LATENCY || o_busy !== 1'b0) begin
			$display("request %0d gave o_valid after %0d edges with o_busy %b at %0t",
				req_index, edges, o_busy, $time);
			timing_errors++;
		end
		check_quotient(req.quo);
		check_err(req.err);
		check_flags(req.flags);
		@(posedge i_clk);
		@(negedge i_clk);
		if (o_valid !== 1'b0) begin
			$display("o_valid stayed high for more than one cycle at %0t", $time);
			timing_errors++;
		end
		// one idle cycle before the next request
		@(posedge i_clk);
		@(negedge i_clk);
	endtask

	////////////////////
	// test sequence
	////////////////////

	// the limit follows the number of requests, each needs under
	// DIV_LATENCY + 4 cycles
	initial begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("the run timed out after %0d cycles without finishing", cycle_count);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		request_t  req;
		div_op_e   op;
		div_word_t num;
		div_word_t den;
		div_word_t r;
		int        total;
		i_reset = 1'b1;
		i_wr = 1'b0;
		i_op = DIV_OP_UNSIGNED;
		i_numerator = '0;
		i_denominator = '0;
		load_patterns();
		cycle_limit = (patterns.size() + 200) * (`DIV_LATENCY + 4) + 100;
		repeat (5) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;
		if (o_busy !== 1'b0 || o_valid !== 1'b0 || o_err !== 1'b0 || o_flags !== '0) begin
			$display("outputs were not cleared by reset at %0t", $time);
			timing_errors++;
		end
		foreach (patterns[i]) begin
			req_index = i;
			run_request(patterns[i]);
		end
		// random divisors get shifted down so quotients cover many sizes,
		// and about one in 32 is forced to zero
		for (int i = 0; i < 200; i++) begin
			req_index = patterns.size() + i;
			r = random_word();
			op = div_op_e'(r[31]);
			num = random_word();
			den = random_word() >> r[4:0];
			if (r[9:5] == 5'd0)
				den = '0;
			req = ref_divide(op, num, den);
			run_request(req);
		end
		total = quotient_errors + errbit_errors + flag_errors + timing_errors + file_errors;
		$display("error counts: quotient %0d, err %0d, flags %0d, timing %0d, file %0d",
			quotient_errors, errbit_errors, flag_errors, timing_errors, file_errors);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
source/div_pkg.sv
source/div_operand_prep.sv
source/div_core.sv
source/div_result.sv
source/div_unit.sv
dv/div_unit_tb.sv

/* Makefile */
# Verilator simulation of the divide unit testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f files.f --top-module div_unit_tb \
		--Mdir obj_dir -o div_unit_sim
	./obj_dir/div_unit_sim | tee $(LOG)
	@if grep -qx "Finished with no errors" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* dv/div_patterns.txt */
# columns in hex: opcode (0 unsigned, 1 signed) numerator denominator
# then the expected quotient, expected err and expected flags (v n c z)
0 00000064 00000007 0000000e 0 0
0 00000003 00000009 00000000 0 1
0 12345678 12345678 00000001 0 0
0 deadbeef 00000001 deadbeef 0 4
0 ffffffff 00000001 ffffffff 0 4
0 ffffffff 00000002 7fffffff 0 0
0 ffffffff ffffffff 00000001 0 0
0 ffffffff 00000010 0fffffff 0 0
0 80000000 00000003 2aaaaaaa 0 0
0 00000000 00000005 00000000 0 1
0 fffffffe ffffffff 00000000 0 1
0 0000ffff 00000100 000000ff 0 0
0 80000000 ffffffff 00000000 0 1
0 00010000 00000010 00001000 0 0
1 00000064 00000007 0000000e 0 0
1 ffffff9c 00000007 fffffff2 0 4
1 00000064 fffffff9 fffffff2 0 4
1 ffffff9c fffffff9 0000000e 0 0
1 80000000 ffffffff 80000000 0 4
1 80000000 00000001 80000000 0 4
1 80000000 00000002 c0000000 0 4
1 7fffffff ffffffff 80000001 0 4
1 00000003 fffffffc 00000000 0 1
1 fffffffd 00000004 00000000 0 1
1 fffffff9 00000002 fffffffd 0 4
1 7fffffff 7fffffff 00000001 0 0
1 ffffffff ffffffff 00000001 0 0
1 00000000 fffffffb 00000000 0 1
1 80000000 80000000 00000001 0 0
1 12345678 00001000 00012345 0 0
1 edcba988 00001000 fffedcbb 0 4
0 00000064 00000000 00000000 1 0
1 ffffff9c 00000000 00000000 1 0
0 00000000 00000000 00000000 1 0
1 80000000 00000000 00000000 1 0
